// File: vlog.f
common/rv_pkg.sv
src/rv_regfile.sv
src/rv_forward.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_pipe_top.sv
verif/tb_rv_pipe.sv

// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP    = tb_rv_pipe
FLIST  = vlog.f
OBJDIR = obj_dir
LOG    = sim.log
BIN    = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verif/tb_rv_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipe;

    import rv_pkg::*;

    localparam int DMEM_WORDS = 64;
    localparam int AW         = $clog2(DMEM_WORDS);

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;                       // Already sign extended or shifted
    } insn_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] cyc;                       // Cycle the write must retire in
    } retire_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    insn_t       prog[$];
    insn_t       cur_insn;
    retire_t     exp_q[$];
    retire_t     head_q;
    logic        head_valid_q;
    logic        accepted_q;
    logic        seen_write_q;
    logic        ex_load_q;
    logic [4:0]  ex_rd_q;
    logic        stall_exp;
    logic [31:0] cycle_q;
    logic [31:0] cycle_limit;
    logic [31:0] regs_m [32];
    logic [31:0] mem_m [DMEM_WORDS];
    int          pushed_cnt;
    int          retired_cnt;
    int          stall_cnt;

    rv_pipe_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .stall_o       (stall),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // ########################################################################
    // Instruction encoding and the architectural model

    function automatic logic [31:0] encode(insn_t i);
        logic [31:0] w;
        case (i.op)
            OP_ADD:  w = {7'h00, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
            OP_SUB:  w = {7'h20, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
            OP_AND:  w = {7'h00, i.rs2, i.rs1, 3'b111, i.rd, 7'b0110011};
            OP_OR:   w = {7'h00, i.rs2, i.rs1, 3'b110, i.rd, 7'b0110011};
            OP_XOR:  w = {7'h00, i.rs2, i.rs1, 3'b100, i.rd, 7'b0110011};
            OP_SLT:  w = {7'h00, i.rs2, i.rs1, 3'b010, i.rd, 7'b0110011};
            OP_ADDI: w = {i.imm[11:0], i.rs1, 3'b000, i.rd, 7'b0010011};
            OP_LUI:  w = {i.imm[31:12], i.rd, 7'b0110111};
            OP_LW:   w = {i.imm[11:0], i.rs1, 3'b010, i.rd, 7'b0000011};
            OP_SW:   w = {i.imm[11:5], i.rs2, i.rs1, 3'b010, i.imm[4:0], 7'b0100011};
            default: w = 32'h0000_0013;
        endcase
        return w;
    endfunction

    function automatic logic reads_reg(insn_t i, logic [4:0] r);
        logic rtype;
        rtype = i.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
        return ((i.op != OP_LUI) && (i.rs1 == r)) ||
               ((rtype || i.op == OP_SW) && (i.rs2 == r));
    endfunction

    task automatic model_step(input insn_t i, input logic [31:0] now);
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   res;
        logic [AW-1:0] idx;
        logic          wr;
        retire_t       r;
        a   = regs_m[i.rs1];
        b   = regs_m[i.rs2];
        res = '0;
        wr  = 1'b1;
        idx = AW'(((a + i.imm) >> 2) % DMEM_WORDS);  // Word index wraps
        case (i.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = a + i.imm;
            OP_LUI:  res = i.imm;
            OP_LW:   res = mem_m[idx];
            OP_SW: begin
                mem_m[idx] = b;
                wr         = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && i.rd != 5'd0) begin           // x0 writes vanish
            regs_m[i.rd] = res;
            r.rd   = i.rd;
            r.data = res;
            r.cyc  = now + 32'd3;
            exp_q.push_back(r);
            pushed_cnt++;
        end
    endtask

    always @(posedge clk) begin : model_update
        logic acc;
        acc = 1'b0;
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs_m[k] = '0;
            end
            for (int k = 0; k < DMEM_WORDS; k++) begin
                mem_m[k] = '0;
            end
            exp_q.delete();
            pushed_cnt   = 0;
            retired_cnt  = 0;
            stall_cnt    = 0;
            cycle_q      <= '0;
            head_q       <= '0;
            head_valid_q <= 1'b0;
            accepted_q   <= 1'b0;
            seen_write_q <= 1'b0;
            ex_load_q    <= 1'b0;
            ex_rd_q      <= '0;
        end else begin
            cycle_q <= cycle_q + 32'd1;
            if (wb_valid) begin
                retired_cnt++;
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
            end
            acc = instr_valid && !stall;
            if (instr_valid && stall) begin
                stall_cnt++;
            end
            if (acc) begin
                model_step(cur_insn, cycle_q);
            end
            if (exp_q.size() != 0) begin
                head_q <= exp_q[0];
            end
            head_valid_q <= (exp_q.size() != 0);
            if (acc && pushed_cnt != 0) begin
                seen_write_q <= 1'b1;
            end
            ex_load_q  <= acc && (cur_insn.op == OP_LW) && (cur_insn.rd != 5'd0);
            ex_rd_q    <= cur_insn.rd;
            accepted_q <= acc;
        end
    end

    always @(posedge clk) begin
        if (cycle_q >= cycle_limit) begin
            report_failure($sformatf("Timeout: run exceeded %0d cycles", cycle_limit));
        end
    end

    // ########################################################################
    // Checks

    assign stall_exp = instr_valid && ex_load_q && reads_reg(cur_insn, ex_rd_q);

    assert property (@(posedge clk) disable iff (!rst_n) !seen_write_q |-> !wb_valid && !stall)
        else report_failure("Strobe or stall raised before any register write");
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> head_valid_q)
        else report_failure("Register write retired with none expected");
    assert property (@(posedge clk) disable iff (!rst_n)
                     wb_valid && head_valid_q |-> wb_rd == head_q.rd)
        else report_failure($sformatf("Mismatch wb_rd_o: got 0x%h, expected 0x%h",
                                      $sampled(wb_rd), $sampled(head_q.rd)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     wb_valid && head_valid_q |-> wb_data == head_q.data)
        else report_failure($sformatf("Mismatch wb_data_o: got 0x%h, expected 0x%h",
                                      $sampled(wb_data), $sampled(head_q.data)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     wb_valid && head_valid_q |-> head_q.cyc == cycle_q)
        else report_failure($sformatf("Mismatch retire cycle: got 0x%h, expected 0x%h",
                                      $sampled(cycle_q), $sampled(head_q.cyc)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     head_valid_q && head_q.cyc == cycle_q |-> wb_valid)
        else report_failure("Expected register write did not retire on time");
    assert property (@(posedge clk) disable iff (!rst_n) stall == stall_exp)
        else report_failure($sformatf("Mismatch stall_o: got 0x%h, expected 0x%h",
                                      $sampled(stall), $sampled(stall_exp)));

    // ########################################################################
    // Stimulus

    task automatic append_insn(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [31:0] imm);
        insn_t i;
        i.op  = op;
        i.rd  = rd;
        i.rs1 = rs1;
        i.rs2 = rs2;
        i.imm = imm;
        prog.push_back(i);
    endtask

    function automatic insn_t random_insn();
        insn_t       i;
        logic [11:0] i12;
        i12   = 12'($urandom);
        i.rd  = 5'($urandom_range(0, 7));       // Small window keeps hazards dense
        i.rs1 = 5'($urandom_range(0, 7));
        i.rs2 = 5'($urandom_range(0, 7));
        i.imm = {{20{i12[11]}}, i12};
        case ($urandom_range(0, 9))
            0: i.op = OP_ADD;
            1: i.op = OP_SUB;
            2: i.op = OP_AND;
            3: i.op = OP_OR;
            4: i.op = OP_XOR;
            5: i.op = OP_SLT;
            6: i.op = OP_ADDI;
            7: begin
                i.op  = OP_LUI;
                i.imm = {20'($urandom), 12'b0};
            end
            8: begin
                i.op  = OP_LW;
                i.imm = 32'($urandom_range(0, DMEM_WORDS - 1)) << 2;
            end
            default: begin
                i.op  = OP_SW;
                i.imm = 32'($urandom_range(0, DMEM_WORDS - 1)) << 2;
            end
        endcase
        return i;
    endfunction

    task automatic issue(input insn_t i);
        cur_insn    = i;
        instr       = encode(i);
        instr_valid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!accepted_q);                // Held while stalled
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        cur_insn    = '0;
        void'($urandom(32'he71b_a51c));

        // Forwarding at distances 1, 2 and 3
        append_insn(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'h0000_0123);
        append_insn(OP_LUI, 5'd2, 5'd0, 5'd0, 32'hABCD_E000);
        append_insn(OP_ADD, 5'd3, 5'd1, 5'd1, '0);          // Both from mem stage
        append_insn(OP_OR, 5'd4, 5'd2, 5'd3, '0);
        append_insn(OP_AND, 5'd5, 5'd1, 5'd4, '0);
        append_insn(OP_SUB, 5'd6, 5'd3, 5'd4, '0);
        append_insn(OP_XOR, 5'd7, 5'd6, 5'd6, '0);          // Both from ex stage
        append_insn(OP_ADDI, 5'd8, 5'd6, 5'd0, 32'hFFFF_FFFF);
        append_insn(OP_SLT, 5'd9, 5'd8, 5'd1, '0);
        append_insn(OP_SLT, 5'd10, 5'd1, 5'd8, '0);
        append_insn(OP_ADDI, 5'd11, 5'd0, 5'd0, 32'h0000_0007);
        append_insn(OP_ADD, 5'd12, 5'd9, 5'd9, '0);         // Both from wb stage
        // x0 stays zero
        append_insn(OP_ADDI, 5'd0, 5'd0, 5'd0, 32'h0000_0055);
        append_insn(OP_ADD, 5'd13, 5'd0, 5'd0, '0);
        append_insn(OP_LUI, 5'd0, 5'd0, 5'd0, 32'h1234_5000);
        append_insn(OP_ADDI, 5'd14, 5'd0, 5'd0, 32'h0000_0001);
        // Memory round trip and load-use
        append_insn(OP_ADDI, 5'd15, 5'd0, 5'd0, 32'h0000_0040);
        append_insn(OP_LUI, 5'd16, 5'd0, 5'd0, 32'h1234_5000);
        append_insn(OP_ADDI, 5'd16, 5'd16, 5'd0, 32'h0000_0678);
        append_insn(OP_SW, 5'd0, 5'd15, 5'd16, 32'h0000_0008);
        append_insn(OP_LW, 5'd17, 5'd15, 5'd0, 32'h0000_0008);
        append_insn(OP_ADD, 5'd18, 5'd17, 5'd17, '0);       // One bubble
        append_insn(OP_LW, 5'd19, 5'd15, 5'd0, 32'h0000_0008);
        append_insn(OP_ADDI, 5'd20, 5'd0, 5'd0, 32'h0000_0001);
        append_insn(OP_ADD, 5'd21, 5'd19, 5'd20, '0);       // Load data from mem stage
        append_insn(OP_LW, 5'd22, 5'd15, 5'd0, 32'h0000_0008);
        append_insn(OP_SW, 5'd0, 5'd15, 5'd22, 32'h0000_000C);
        append_insn(OP_LW, 5'd23, 5'd15, 5'd0, 32'h0000_000C);
        append_insn(OP_ADD, 5'd24, 5'd23, 5'd0, '0);
        for (int k = 0; k < 300; k++) begin
            prog.push_back(random_insn());
        end
        cycle_limit = 32'(4 * prog.size() + 100);

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        foreach (prog[k]) begin
            issue(prog[k]);
        end
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (8) @(posedge clk);
        #1;

        if (stall_cnt == 0) begin
            report_failure("No load-use stall occurred during the run");
        end else if (retired_cnt != pushed_cnt) begin
            report_failure($sformatf("Retired %0d writes, expected %0d",
                                     retired_cnt, pushed_cnt));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    output logic        stall_o,
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);

    import rv_pkg::*;

    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    fwd_src_t ex_src;
    fwd_src_t mem_src;
    fwd_src_t wb_src;

    // ########################################################################
    // Stages

    rv_decode u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .ex_src_i      (ex_src),
        .mem_src_i     (mem_src),
        .wb_src_i      (wb_src),
        .wb_i          (mem_wb),
        .stall_o       (stall_o),
        .id_ex_o       (id_ex)
    );

    rv_execute u_execute (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_src_o (ex_src),
        .ex_mem_o (ex_mem)
    );

    rv_result #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_result (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ex_mem_i  (ex_mem),
        .mem_src_o (mem_src),
        .mem_wb_o  (mem_wb)
    );

    // ########################################################################
    // Writeback

    assign wb_src = '{
        wr_en: mem_wb.valid && mem_wb.wr_en,
        rd:    mem_wb.rd,
        dest:  mem_wb.dest,
        alu:   mem_wb.alu,
        mdata: mem_wb.rdata
    };

    assign wb_valid_o = mem_wb.valid && mem_wb.wr_en;  // Stores and bubbles stay quiet
    assign wb_rd_o    = mem_wb.rd;
    assign wb_data_o  = wb_value(mem_wb);

endmodule

`default_nettype wire

// File: src/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result #(
    parameter int DMEM_WORDS = 64
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  rv_pkg::ex_mem_t  ex_mem_i,
    output rv_pkg::fwd_src_t mem_src_o,
    output rv_pkg::mem_wb_t  mem_wb_o
);

    import rv_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    ex_mem_t     ex_mem_q;
    mem_wb_t     mem_wb_q;
    logic [31:0] dmem_q [DMEM_WORDS];
    logic [AW-1:0] widx;
    logic [31:0] rdata;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_mem_i;
        end
    end

    assign widx  = ex_mem_q.alu[AW+1:2];        // Word index wraps on memory size
    assign rdata = dmem_q[widx];                // Combinational read

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < DMEM_WORDS; k++) begin
                dmem_q[k] <= '0;
            end
        end else if (ex_mem_q.valid && ex_mem_q.store) begin
            dmem_q[widx] <= ex_mem_q.st_data;
        end
    end

    assign mem_src_o = '{
        wr_en: ex_mem_q.valid && ex_mem_q.wr_en,
        rd:    ex_mem_q.rd,
        dest:  ex_mem_q.dest,
        alu:   ex_mem_q.alu,
        mdata: rdata
    };

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= '{
                valid: ex_mem_q.valid,
                rd:    ex_mem_q.rd,
                wr_en: ex_mem_q.wr_en,
                dest:  ex_mem_q.dest,
                alu:   ex_mem_q.alu,
                rdata: rdata
            };
        end
    end

    assign mem_wb_o = mem_wb_q;

endmodule

`default_nettype wire

// File: src/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  rv_pkg::id_ex_t   id_ex_i,
    output rv_pkg::fwd_src_t ex_src_o,
    output rv_pkg::ex_mem_t  ex_mem_o
);

    import rv_pkg::*;

    id_ex_t      id_ex_q;
    logic [31:0] alu;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_i;
        end
    end

    always_comb begin
        case (id_ex_q.op)
            OP_ADD, OP_ADDI, OP_LW, OP_SW: alu = id_ex_q.opa + id_ex_q.opb;  // Address add too
            OP_SUB:  alu = id_ex_q.opa - id_ex_q.opb;
            OP_AND:  alu = id_ex_q.opa & id_ex_q.opb;
            OP_OR:   alu = id_ex_q.opa | id_ex_q.opb;
            OP_XOR:  alu = id_ex_q.opa ^ id_ex_q.opb;
            OP_SLT:  alu = {31'b0, $signed(id_ex_q.opa) < $signed(id_ex_q.opb)};
            OP_LUI:  alu = id_ex_q.opb;
            default: alu = '0;
        endcase
    end

    assign ex_mem_o = '{
        valid:   id_ex_q.valid,
        rd:      id_ex_q.rd,
        wr_en:   id_ex_q.wr_en,
        dest:    id_ex_q.dest,
        alu:     alu,
        st_data: id_ex_q.st_data,
        store:   id_ex_q.valid && (id_ex_q.op == OP_SW)
    };

    // Load data not yet read here
    assign ex_src_o = '{
        wr_en: id_ex_q.valid && id_ex_q.wr_en,
        rd:    id_ex_q.rd,
        dest:  id_ex_q.dest,
        alu:   alu,
        mdata: '0
    };

    assert property (@(posedge clk_i) disable iff (!rst_n_i) id_ex_q.wr_en |-> id_ex_q.valid)
        else $error("wr_en without valid in ex stage");

endmodule

`default_nettype wire

// File: src/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             instr_valid_i,
    input  rv_pkg::instr_u   instr_i,
    input  rv_pkg::fwd_src_t ex_src_i,
    input  rv_pkg::fwd_src_t mem_src_i,
    input  rv_pkg::fwd_src_t wb_src_i,
    input  rv_pkg::mem_wb_t  wb_i,
    output logic             stall_o,
    output rv_pkg::id_ex_t   id_ex_o
);

    import rv_pkg::*;

    op_e         op;
    dest_e       dest;
    logic        use_rs1;
    logic        use_rs2;
    logic        rtype;
    logic [31:0] imm;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rf1;
    logic [31:0] rf2;
    logic [31:0] fwd1;
    logic [31:0] fwd2;
    logic        load_use;

    assign rs1_addr = instr_i.r.rs1;
    assign rs2_addr = instr_i.r.rs2;            // Same bits in the S view

    // ########################################################################
    // Opcode decode

    always_comb begin
        op = OP_NOP;
        case (instr_i.r.opcode)
            OPC_OP: begin
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {7'h00, 3'b000}: op = OP_ADD;
                    {7'h20, 3'b000}: op = OP_SUB;
                    {7'h00, 3'b111}: op = OP_AND;
                    {7'h00, 3'b110}: op = OP_OR;
                    {7'h00, 3'b100}: op = OP_XOR;
                    {7'h00, 3'b010}: op = OP_SLT;
                    default:         op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: op = (instr_i.i.funct3 == 3'b000) ? OP_ADDI : OP_NOP;
            OPC_LUI:    op = OP_LUI;
            OPC_LOAD:   op = (instr_i.i.funct3 == 3'b010) ? OP_LW : OP_NOP;
            OPC_STORE:  op = (instr_i.s.funct3 == 3'b010) ? OP_SW : OP_NOP;
            default:    op = OP_NOP;
        endcase
    end

    always_comb begin
        rtype   = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
        use_rs1 = !(op inside {OP_NOP, OP_LUI});
        use_rs2 = rtype || (op == OP_SW);
        case (op)
            OP_LW:          dest = DEST_MEM;
            OP_SW, OP_NOP:  dest = DEST_NONE;
            default:        dest = DEST_ALU;
        endcase
        case (op)
            OP_SW:   imm = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            OP_LUI:  imm = {instr_i.u.imm20, 12'b0};
            default: imm = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
        endcase
    end

    // ########################################################################
    // Operand read and hazard check

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_addr1_i (rs1_addr),
        .rd_addr2_i (rs2_addr),
        .rd_data1_o (rf1),
        .rd_data2_o (rf2),
        .wr_en_i    (wb_i.valid & wb_i.wr_en),
        .wr_addr_i  (wb_i.rd),
        .wr_data_i  (wb_value(wb_i))
    );

    rv_forward u_forward (
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_rf_i   (rf1),
        .rs2_rf_i   (rf2),
        .ex_src_i   (ex_src_i),
        .mem_src_i  (mem_src_i),
        .wb_src_i   (wb_src_i),
        .rs1_o      (fwd1),
        .rs2_o      (fwd2)
    );

    // Load in ex has no data yet
    assign load_use = ex_src_i.wr_en && (ex_src_i.dest == DEST_MEM) &&
                      ((use_rs1 && ex_src_i.rd == rs1_addr) ||
                       (use_rs2 && ex_src_i.rd == rs2_addr));
    assign stall_o  = instr_valid_i && load_use;

    always_comb begin
        id_ex_o         = '0;                   // Bubble unless accepted
        id_ex_o.valid   = instr_valid_i && !stall_o;
        id_ex_o.op      = id_ex_o.valid ? op : OP_NOP;
        id_ex_o.rd      = instr_i.r.rd;
        id_ex_o.wr_en   = id_ex_o.valid && (dest != DEST_NONE) && (instr_i.r.rd != 5'd0);
        id_ex_o.dest    = dest;
        id_ex_o.opa     = (op == OP_LUI) ? '0 : fwd1;
        id_ex_o.opb     = rtype ? fwd2 : imm;
        id_ex_o.st_data = fwd2;
    end

    // One bubble clears the hazard
    assert property (@(posedge clk_i) disable iff (!rst_n_i) stall_o |=> !stall_o)
        else $error("stall_o high two cycles in a row");

endmodule

`default_nettype wire

// File: src/rv_forward.sv
`timescale 1ns/1ps
`default_nettype none

module rv_forward (
    input  logic [4:0]       rs1_addr_i,
    input  logic [4:0]       rs2_addr_i,
    input  logic [31:0]      rs1_rf_i,
    input  logic [31:0]      rs2_rf_i,
    input  rv_pkg::fwd_src_t ex_src_i,
    input  rv_pkg::fwd_src_t mem_src_i,
    input  rv_pkg::fwd_src_t wb_src_i,
    output logic [31:0]      rs1_o,
    output logic [31:0]      rs2_o
);

    import rv_pkg::*;

    function automatic logic hit(fwd_src_t s, logic [4:0] addr);
        return s.wr_en && (s.rd != 5'd0) && (s.rd == addr);
    endfunction

    function automatic logic [31:0] value(fwd_src_t s);
        return (s.dest == DEST_MEM) ? s.mdata : s.alu;
    endfunction

    // Youngest writer first
    function automatic logic [31:0] pick(logic [4:0] addr, logic [31:0] rf,
                                         fwd_src_t ex_s, fwd_src_t mem_s,
                                         fwd_src_t wb_s);
        if (hit(ex_s, addr)) begin
            return value(ex_s);                 // Load here is stalled by decode
        end else if (hit(mem_s, addr)) begin
            return value(mem_s);
        end else if (hit(wb_s, addr)) begin
            return value(wb_s);                 // Covers same-cycle RF write
        end
        return rf;
    endfunction

    assign rs1_o = pick(rs1_addr_i, rs1_rf_i, ex_src_i, mem_src_i, wb_src_i);
    assign rs2_o = pick(rs2_addr_i, rs2_rf_i, ex_src_i, mem_src_i, wb_src_i);

    // A writing stage must say where its result comes from
    always_comb begin
        assert (!(ex_src_i.wr_en && ex_src_i.dest == DEST_NONE))
            else $error("ex source writes with DEST_NONE");
        assert (!(mem_src_i.wr_en && mem_src_i.dest == DEST_NONE))
            else $error("mem source writes with DEST_NONE");
        assert (!(wb_src_i.wr_en && wb_src_i.dest == DEST_NONE))
            else $error("wb source writes with DEST_NONE");
    end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  rd_addr1_i,
    input  logic [4:0]  rd_addr2_i,
    output logic [31:0] rd_data1_o,
    output logic [31:0] rd_data2_o,
    input  logic        wr_en_i,
    input  logic [4:0]  wr_addr_i,
    input  logic [31:0] wr_data_i
);

    logic [31:0] regs_q [32];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 32; k++) begin
                regs_q[k] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != 5'd0) begin  // x0 never written
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data1_o = (rd_addr1_i == 5'd0) ? '0 : regs_q[rd_addr1_i];
    assign rd_data2_o = (rd_addr2_i == 5'd0) ? '0 : regs_q[rd_addr2_i];

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLT, OP_ADDI, OP_LUI, OP_LW, OP_SW
    } op_e;

    typedef enum logic [1:0] {
        DEST_NONE,
        DEST_ALU,
        DEST_MEM                               // Result comes from data memory
    } dest_e;

    // ########################################################################
    // Instruction word views

    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_view_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        u_view_t u;
    } instr_u;

    // ########################################################################
    // Stage bundles

    typedef struct packed {
        logic        valid;
        op_e         op;
        logic [4:0]  rd;
        logic        wr_en;
        dest_e       dest;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] st_data;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        wr_en;
        dest_e       dest;
        logic [31:0] alu;
        logic [31:0] st_data;
        logic        store;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        wr_en;
        dest_e       dest;
        logic [31:0] alu;
        logic [31:0] rdata;
    } mem_wb_t;

    typedef struct packed {
        logic        wr_en;
        logic [4:0]  rd;
        dest_e       dest;
        logic [31:0] alu;
        logic [31:0] mdata;
    } fwd_src_t;

    function automatic logic [31:0] wb_value(mem_wb_t w);
        return (w.dest == DEST_MEM) ? w.rdata : w.alu;
    endfunction

endpackage

`default_nettype wire
